// ==== design/fdc_pkg.sv ====
// floppy controller shared definitions
package fdc_pkg;

	// ============================================================
	// host register map
	// ============================================================
	localparam logic [1:0] A_STATUS = 2'd0; // command on write
	localparam logic [1:0] A_TRACK  = 2'd1;
	localparam logic [1:0] A_SECTOR = 2'd2;
	localparam logic [1:0] A_DATA   = 2'd3;

	// ============================================================
	// timing, in ce ticks
	// ============================================================
	localparam int unsigned WATCHDOG_CYCLES = 4096; // host time to serve one drq
	localparam int unsigned BYTE_GAP_CYCLES = 16;   // drq spacing
	localparam int unsigned SETTLE_CYCLES   = 4000; // type I busy time
	localparam int unsigned SEEK_CYCLES     = 1024; // head settle before transfer

	typedef enum logic [2:0] {
		OP_NONE,
		OP_RESTORE,
		OP_SEEK,
		OP_STEP,
		OP_READ_SECTOR,
		OP_WRITE_SECTOR,
		OP_FORCE_INT
	} fdc_op_e;

	// registers -> sequencer
	typedef struct packed {
		logic    start;    // one ce tick per accepted command
		fdc_op_e op;
		logic    multi;    // multi-sector
		logic    wp_fault; // write on a protected disk
		logic    served;   // host took or gave a data byte
	} fdc_cmd_t;

	// sequencer -> registers
	typedef struct packed {
		logic busy;
		logic drq;
		logic done;       // raises intrq
		logic sector_inc;
		logic seek_err;
		logic wr_fault;
		logic lost_data;
		logic xfer;       // data port reads the buffer
	} fdc_seq_t;

	typedef struct packed {
		logic [19:0] byte_offset;
		logic [7:0]  sectors_per_track;
		logic [10:0] sector_bytes;
	} fdc_geom_t;

	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

endpackage

// ==== design/fdc_geometry.sv ====
// disk image geometry
`timescale 1ns/1ns
module fdc_geometry (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  logic [2:0]          size_code,
	input  logic [7:0]          track,
	input  logic                side,
	input  logic [7:0]          sector,
	output fdc_pkg::fdc_geom_t  geom
);
	logic [7:0]  spt;
	logic [1:0]  shift; // log2 of sector size / 128
	logic [15:0] index;

	// fixed layouts in track-side-sector order
	always_comb begin
		case (size_code)
			3'd1: begin
				spt = 8'd16;
				shift = 2'd1;
			end
			3'd2: begin
				spt = 8'd9;
				shift = 2'd2;
			end
			3'd3: begin
				spt = 8'd5;
				shift = 2'd3;
			end
			3'd4: begin
				spt = 8'd10;
				shift = 2'd2;
			end
			default: begin // 26 x 128
				spt = 8'd26;
				shift = 2'd0;
			end
		endcase
	end

	assign index = 16'({track, side}) * 16'(spt) + 16'(sector) - 16'd1;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			geom <= '0;
		end else begin
			geom.byte_offset       <= 20'(index) << (5'd7 + 5'(shift));
			geom.sectors_per_track <= spt;
			geom.sector_bytes      <= 11'd128 << shift;
		end
	end
endmodule

// ==== design/sector_buffer.sv ====
// sector buffer, dual port ram
`timescale 1ns/1ns
module sector_buffer (
	input  logic        clk_sys,
	// storage side
	input  logic [10:0] a_addr,
	input  logic [7:0]  a_wdata,
	input  logic        a_we,
	output logic [7:0]  a_rdata,
	// host side
	input  logic [10:0] b_addr,
	input  logic [7:0]  b_wdata,
	input  logic        b_we,
	output logic [7:0]  b_rdata
);
	logic [7:0] ram [0:2047];

	always @(posedge clk_sys) begin
		if (a_we) begin
			ram[a_addr] <= a_wdata;
			a_rdata <= a_wdata; // write-through
		end else begin
			a_rdata <= ram[a_addr];
		end
	end

	always @(posedge clk_sys) begin
		if (b_we) begin
			ram[b_addr] <= b_wdata;
			b_rdata <= b_wdata;
		end else begin
			b_rdata <= ram[b_addr];
		end
	end
endmodule

// ==== design/fdc_registers.sv ====
// fdc host registers and command decode
`timescale 1ns/1ns
module fdc_registers (
	input  logic               clk_sys,
	input  logic               arst_n,
	input  logic               ce,
	input  logic               io_en,
	input  logic               rd,
	input  logic               wr,
	input  logic [1:0]         addr,
	input  logic [7:0]         din,
	input  logic               ready,
	input  logic               wp,
	input  logic               side_sel,
	input  fdc_pkg::fdc_seq_t  seq,
	input  logic [7:0]         buff_byte,
	output logic [7:0]         dout,
	output logic               intrq,
	output fdc_pkg::fdc_cmd_t  cmd,
	output logic [7:0]         track,
	output logic               side,
	output logic [7:0]         sector
);
	logic       rde, wre;
	logic       old_rd, old_wr;
	logic       wr_rise, rd_fall, wr_fall;
	logic [1:0] cur_addr;            // address latched at strobe start
	logic [7:0] track_reg, sector_reg, data_reg;
	logic [7:0] head_pos;            // real head position
	logic [7:0] next_track;
	logic       step_dir;            // 1 = out
	logic       head_loaded, status_mode, wpe;
	logic [7:0] status;
	logic       cmd_start, cmd_multi, cmd_wpf;
	fdc_pkg::fdc_op_e cmd_op;

	assign rde = rd & io_en;
	assign wre = wr & io_en;
	assign wr_rise = ce & wre & ~old_wr;
	assign rd_fall = ce & old_rd & ~rde;
	assign wr_fall = ce & old_wr & ~wre;

	assign next_track = (din[6] ? din[5] : step_dir) ? head_pos - 8'd1 : head_pos + 8'd1;

	assign cmd.start    = cmd_start;
	assign cmd.op       = cmd_op;
	assign cmd.multi    = cmd_multi;
	assign cmd.wp_fault = cmd_wpf;
	assign cmd.served   = (rd_fall | wr_fall) & (cur_addr == fdc_pkg::A_DATA);

	assign track  = head_pos;
	assign sector = sector_reg;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			{old_rd, old_wr, cur_addr} <= '0;
			{track_reg, sector_reg, data_reg, head_pos} <= '0;
			{step_dir, head_loaded, status_mode, intrq, side} <= '0;
			wpe <= 1'b1;
			{cmd_start, cmd_multi, cmd_wpf} <= '0;
			cmd_op <= fdc_pkg::OP_NONE;
		end else if (ce) begin
			old_rd <= rde;
			old_wr <= wre;
			cmd_start <= 1'b0;
			if ((rde & ~old_rd) | wr_rise) cur_addr <= addr;

			if (rd_fall && cur_addr == fdc_pkg::A_STATUS) intrq <= 1'b0;
			if (seq.done) intrq <= 1'b1;
			if (seq.sector_inc) sector_reg <= sector_reg + 8'd1;

			if (wr_rise) begin
				case (addr)
					fdc_pkg::A_STATUS: begin
						intrq <= 1'b0;
						if (!seq.busy || din[7:4] == 4'hd) begin
							status_mode <= din[7];
							wpe <= ~din[7];
							side <= side_sel;
							cmd_multi <= din[4];
							cmd_wpf <= 1'b0;
							cmd_start <= 1'b1;
							case (din[7:4])
								4'h0: begin // restore
									head_loaded <= din[3];
									track_reg <= 8'd0;
									head_pos <= 8'd0;
									cmd_op <= fdc_pkg::OP_RESTORE;
								end
								4'h1: begin
									head_loaded <= din[3];
									track_reg <= data_reg;
									head_pos <= data_reg;
									cmd_op <= fdc_pkg::OP_SEEK;
								end
								4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7: begin
									if (din[6]) step_dir <= din[5]; // remember direction
									head_pos <= next_track;
									if (din[4]) track_reg <= next_track;
									head_loaded <= din[3];
									cmd_op <= fdc_pkg::OP_STEP;
								end
								4'h8, 4'h9: cmd_op <= fdc_pkg::OP_READ_SECTOR;
								4'ha, 4'hb: begin
									wpe <= 1'b1;
									cmd_wpf <= wp;
									cmd_op <= fdc_pkg::OP_WRITE_SECTOR;
								end
								4'hd: begin
									status_mode <= 1'b0;
									cmd_op <= fdc_pkg::OP_FORCE_INT;
								end
								default: cmd_start <= 1'b0; // track-level commands unsupported
							endcase
						end
					end
					fdc_pkg::A_TRACK:  if (!seq.busy) track_reg <= din;
					fdc_pkg::A_SECTOR: if (!seq.busy) sector_reg <= din;
					default:           data_reg <= din;
				endcase
			end
		end
	end

	// type I or type II layout, index and crc bits read 0
	assign status = status_mode ?
		{~ready, wp & wpe, seq.wr_fault, seq.seek_err | ~ready, 1'b0,
			seq.lost_data, seq.drq, seq.busy} :
		{~ready, wp & wpe, head_loaded, seq.seek_err | ~ready, 1'b0,
			head_pos == 8'd0, 1'b0, seq.busy};

	always_comb begin
		case (addr)
			fdc_pkg::A_STATUS: dout = status;
			fdc_pkg::A_TRACK:  dout = track_reg;
			fdc_pkg::A_SECTOR: dout = sector_reg;
			default:           dout = seq.xfer ? buff_byte : data_reg;
		endcase
	end
endmodule

// ==== design/fdc_sequencer.sv ====
// fdc command sequencer
`timescale 1ns/1ns
module fdc_sequencer (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  logic                ce,
	input  logic                ready,
	input  fdc_pkg::fdc_cmd_t   cmd,
	input  fdc_pkg::fdc_geom_t  geom,
	input  logic [7:0]          sector,
	input  logic                byte_served,
	input  logic                sd_ack,
	output fdc_pkg::fdc_seq_t   seq,
	output fdc_pkg::sd_req_t    sd,
	output logic [1:0]          block,
	output logic [10:0]         byte_addr,
	output logic                buf_we
);
	typedef enum logic [3:0] {
		S_IDLE, S_SETTLE, S_SEEK, S_CHECK, S_FETCH, S_FETCH_WAIT,
		S_GAP, S_DRQ, S_STORE, S_STORE_WAIT, S_END, S_DONE
	} state_e;

	state_e      state;
	logic [12:0] cnt;       // settle, seek, gap and watchdog
	logic [10:0] length;    // bytes left in sector
	logic [10:0] blk_end;
	logic [1:0]  blk_max;   // last block touched by the sector
	logic [1:0]  ack_q;
	logic        sd_busy, sd_rd, sd_wr;
	logic        writing, multi, last_sector, bark;
	logic        busy, drq, done, sector_inc, seek_err, wr_fault, lost_data, xfer;

	assign blk_end = {2'b00, geom.byte_offset[8:0]} + geom.sector_bytes - 11'd1;
	assign bark = (cnt == 13'd0);
	assign last_sector = !multi || sector >= geom.sectors_per_track;
	assign buf_we = (state == S_DRQ) && writing && byte_served;

	assign sd.lba = 32'(geom.byte_offset[19:9]) + 32'(block);
	assign sd.rd  = sd_rd;
	assign sd.wr  = sd_wr;

	assign seq = '{busy: busy, drq: drq, done: done, sector_inc: sector_inc,
		seek_err: seek_err, wr_fault: wr_fault, lost_data: lost_data, xfer: xfer};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			{cnt, length, blk_max, block, byte_addr} <= '0;
			{ack_q, sd_busy, sd_rd, sd_wr, writing, multi} <= '0;
			{busy, drq, done, sector_inc, seek_err, wr_fault, lost_data, xfer} <= '0;
		end else if (ce) begin
			done <= 1'b0;
			sector_inc <= 1'b0;

			// storage handshake, drop request on ack rise, block done on fall
			ack_q <= {ack_q[0], sd_ack};
			if (ack_q == 2'b01) {sd_rd, sd_wr} <= 2'b00;
			if (ack_q == 2'b10) sd_busy <= 1'b0;

			case (state)
				S_IDLE: ;
				S_SETTLE: begin
					if (cnt != 13'd0) cnt <= cnt - 13'd1;
					else state <= S_END;
				end
				S_SEEK: begin // geometry settles meanwhile
					if (cnt != 13'd0) cnt <= cnt - 13'd1;
					else state <= S_CHECK;
				end
				S_CHECK: begin
					block <= 2'd0;
					byte_addr <= {2'b00, geom.byte_offset[8:0]};
					length <= geom.sector_bytes;
					blk_max <= blk_end[10:9];
					if (!ready || sector == 8'd0 || sector > geom.sectors_per_track) begin
						seek_err <= 1'b1;
						state <= S_END;
					end else begin
						state <= S_FETCH;
					end
				end
				// ====================================================
				// block fetch, also before writes
				// ====================================================
				S_FETCH: begin
					sd_rd <= 1'b1;
					sd_busy <= 1'b1;
					state <= S_FETCH_WAIT;
				end
				S_FETCH_WAIT: if (!sd_busy) begin
					if (block != blk_max) begin
						block <= block + 2'd1;
						state <= S_FETCH;
					end else begin
						block <= 2'd0;
						xfer <= 1'b1;
						cnt <= 13'(fdc_pkg::BYTE_GAP_CYCLES - 1);
						state <= S_GAP;
					end
				end
				// ====================================================
				// byte loop with the host
				// ====================================================
				S_GAP: begin
					if (cnt != 13'd0) begin
						cnt <= cnt - 13'd1;
					end else begin
						drq <= 1'b1;
						cnt <= 13'(fdc_pkg::WATCHDOG_CYCLES);
						state <= S_DRQ;
					end
				end
				S_DRQ: begin
					if (!bark) cnt <= cnt - 13'd1;
					if (byte_served || bark) begin
						drq <= 1'b0;
						if (bark && !byte_served) lost_data <= 1'b1; // byte skipped
						if (length != 11'd1) begin
							byte_addr <= byte_addr + 11'd1;
							length <= length - 11'd1;
							cnt <= 13'(fdc_pkg::BYTE_GAP_CYCLES - 1);
							state <= S_GAP;
						end else if (writing) begin
							state <= S_STORE;
						end else if (last_sector) begin
							state <= S_END;
						end else begin
							sector_inc <= 1'b1;
							xfer <= 1'b0;
							cnt <= 13'(fdc_pkg::SEEK_CYCLES - 1);
							state <= S_SEEK;
						end
					end
				end
				S_STORE: begin
					sd_wr <= 1'b1;
					sd_busy <= 1'b1;
					state <= S_STORE_WAIT;
				end
				S_STORE_WAIT: if (!sd_busy) begin
					if (block != blk_max) begin
						block <= block + 2'd1;
						state <= S_STORE;
					end else if (last_sector) begin
						state <= S_END;
					end else begin
						sector_inc <= 1'b1;
						xfer <= 1'b0;
						cnt <= 13'(fdc_pkg::SEEK_CYCLES - 1);
						state <= S_SEEK;
					end
				end
				S_END: begin
					{drq, xfer, sd_rd, sd_wr, sd_busy} <= '0;
					done <= 1'b1;
					state <= S_DONE;
				end
				S_DONE: begin
					busy <= 1'b0; // falls with intrq rising
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase

			// new command overrides the running state
			if (cmd.start) begin
				{seek_err, wr_fault, lost_data} <= '0;
				case (cmd.op)
					fdc_pkg::OP_FORCE_INT: begin
						if (busy) state <= S_END;
					end
					fdc_pkg::OP_READ_SECTOR, fdc_pkg::OP_WRITE_SECTOR: begin
						busy <= 1'b1;
						writing <= (cmd.op == fdc_pkg::OP_WRITE_SECTOR);
						multi <= cmd.multi;
						if (cmd.wp_fault) begin
							wr_fault <= 1'b1;
							cnt <= 13'(fdc_pkg::SETTLE_CYCLES - 1);
							state <= S_SETTLE;
						end else begin
							cnt <= 13'(fdc_pkg::SEEK_CYCLES - 1);
							state <= S_SEEK;
						end
					end
					fdc_pkg::OP_RESTORE, fdc_pkg::OP_SEEK, fdc_pkg::OP_STEP: begin
						busy <= 1'b1;
						cnt <= 13'(fdc_pkg::SETTLE_CYCLES - 1);
						state <= S_SETTLE;
					end
					default: ;
				endcase
			end
		end
	end
endmodule

// ==== design/fdc_top.sv ====
// wd1793 style floppy controller
`timescale 1ns/1ns
module fdc_top (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        ce,
	// host bus
	input  logic        io_en,
	input  logic        rd,
	input  logic        wr,
	input  logic [1:0]  addr,
	input  logic [7:0]  din,
	output logic [7:0]  dout,
	output logic        drq,
	output logic        intrq,
	output logic        busy,
	// drive
	input  logic        wp,
	input  logic [2:0]  size_code,
	input  logic        side,
	input  logic        ready,
	// storage
	output logic [31:0] sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	input  logic        sd_ack,
	input  logic [8:0]  sd_buff_addr,
	input  logic [7:0]  sd_buff_dout,
	output logic [7:0]  sd_buff_din,
	input  logic        sd_buff_wr
);
	fdc_pkg::fdc_cmd_t  cmd;
	fdc_pkg::fdc_seq_t  seq;
	fdc_pkg::fdc_geom_t geom;
	fdc_pkg::sd_req_t   sd;
	logic [7:0]  track, sector, buff_byte;
	logic        side_q;
	logic [1:0]  block;
	logic [10:0] byte_addr;
	logic        buf_we;

	assign drq    = seq.drq;
	assign busy   = seq.busy;
	assign sd_lba = sd.lba;
	assign sd_rd  = sd.rd;
	assign sd_wr  = sd.wr;

	fdc_registers u_regs (
		.clk_sys(clk_sys), .arst_n(arst_n), .ce(ce), .io_en(io_en),
		.rd(rd), .wr(wr), .addr(addr), .din(din), .ready(ready), .wp(wp),
		.side_sel(side), .seq(seq), .buff_byte(buff_byte), .dout(dout),
		.intrq(intrq), .cmd(cmd), .track(track), .side(side_q), .sector(sector)
	);

	fdc_geometry u_geom (
		.clk_sys(clk_sys), .arst_n(arst_n), .size_code(size_code),
		.track(track), .side(side_q), .sector(sector), .geom(geom)
	);

	sector_buffer u_buf (
		.clk_sys(clk_sys),
		.a_addr({block, sd_buff_addr}), .a_wdata(sd_buff_dout),
		.a_we(sd_buff_wr), .a_rdata(sd_buff_din),
		.b_addr(byte_addr), .b_wdata(din), .b_we(buf_we), .b_rdata(buff_byte)
	);

	fdc_sequencer u_seq (
		.clk_sys(clk_sys), .arst_n(arst_n), .ce(ce), .ready(ready),
		.cmd(cmd), .geom(geom), .sector(sector), .byte_served(cmd.served),
		.sd_ack(sd_ack), .seq(seq), .sd(sd), .block(block),
		.byte_addr(byte_addr), .buf_we(buf_we)
	);
endmodule

// ==== tests/sd_image_model.sv ====
// behavioral storage for a disk image
`timescale 1ns/1ns
module sd_image_model (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic [31:0] lba,
	input  logic        rd,
	input  logic        wr,
	output logic        ack,
	output logic [8:0]  buff_addr,
	output logic [7:0]  buff_dout,
	input  logic [7:0]  buff_din,
	output logic        buff_wr
);
	logic [7:0]  mem [0:65535]; // 64 KiB image loaded by the testbench
	logic [15:0] base;
	logic [31:0] last_lba;       // block address of the latest request
	logic        writing;
	int          req_count;      // blocks served so far
	int          k;

	initial begin
		ack = 1'b0;
		buff_addr = '0;
		buff_dout = '0;
		buff_wr = 1'b0;
		last_lba = '0;
		req_count = 0;
		forever begin
			@(negedge clk_sys);
			if (arst_n && (rd || wr)) begin
				writing = wr;
				last_lba = lba;
				base = {lba[6:0], 9'd0};
				repeat (3) @(negedge clk_sys); // access latency
				if (writing) begin
					// buffer read data shows one clock after the address
					ack = 1'b1;
					buff_addr = '0;
					for (k = 0; k < 512; k++) begin
						@(negedge clk_sys);
						mem[base + 16'(k)] = buff_din;
						buff_addr = 9'(k + 1);
					end
				end else begin
					for (k = 0; k < 512; k++) begin
						ack = 1'b1;
						buff_addr = 9'(k);
						buff_dout = mem[base + 16'(k)];
						buff_wr = 1'b1;
						@(negedge clk_sys);
					end
					buff_wr = 1'b0;
				end
				ack = 1'b0;
				req_count++;
			end
		end
	end
endmodule

// ==== tests/tb_fdc.sv ====
// floppy controller testbench
`timescale 1ns/1ns
module tb_fdc;

	localparam logic [31:0] SEED = 32'h5d41;
	localparam int WAIT_LIMIT = 20000; // clock cycles per wait
	localparam int NROWS = 17;

	typedef struct packed {
		fdc_pkg::fdc_op_e kind;
		logic [7:0]  cmd;
		logic [2:0]  size;
		logic [7:0]  track;      // data register value for type I
		logic        side;
		logic [7:0]  sector;
		logic        wp;
		logic [11:0] count;      // data bytes moved
		logic [7:0]  status;
		logic [7:0]  exp_track;
		logic [7:0]  exp_sector;
	} row_t;

	logic        clk_sys, arst_n, ce, io_en, rd, wr;
	logic [1:0]  addr;
	logic [7:0]  din, dout;
	logic        drq, intrq, busy;
	logic        wp, side, ready;
	logic [2:0]  size_code;
	logic [31:0] sd_lba;
	logic        sd_rd, sd_wr, sd_ack, sd_buff_wr;
	logic [8:0]  sd_buff_addr;
	logic [7:0]  sd_buff_dout, sd_buff_din;

	row_t        rows [0:NROWS-1];
	logic [7:0]  sent [$];   // bytes written by the host
	logic [31:0] rand_state;
	int          i;

	fdc_top DUT (
		.clk_sys(clk_sys), .arst_n(arst_n), .ce(ce), .io_en(io_en),
		.rd(rd), .wr(wr), .addr(addr), .din(din), .dout(dout),
		.drq(drq), .intrq(intrq), .busy(busy), .wp(wp),
		.size_code(size_code), .side(side), .ready(ready),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_ack(sd_ack),
		.sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout),
		.sd_buff_din(sd_buff_din), .sd_buff_wr(sd_buff_wr)
	);

	sd_image_model img (
		.clk_sys(clk_sys), .arst_n(arst_n), .lba(sd_lba), .rd(sd_rd),
		.wr(sd_wr), .ack(sd_ack), .buff_addr(sd_buff_addr),
		.buff_dout(sd_buff_dout), .buff_din(sd_buff_din), .buff_wr(sd_buff_wr)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ============================================================
	// reference model helpers
	// ============================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] image_byte(input int n);
		logic [31:0] y;
		y = xorshift32(SEED + n);
		return y[7:0];
	endfunction

	function automatic int sectors_per_track(input logic [2:0] size);
		case (size)
			3'd1: return 16;
			3'd2: return 9;
			3'd3: return 5;
			3'd4: return 10;
			default: return 26;
		endcase
	endfunction

	function automatic int sector_length(input logic [2:0] size);
		case (size)
			3'd1: return 256;
			3'd2, 3'd4: return 512;
			3'd3: return 1024;
			default: return 128;
		endcase
	endfunction

	// track-side-sector order
	function automatic int image_offset(input logic [2:0] size, input int trk,
		input int sd, input int sec);
		return ((trk * 2 + sd) * sectors_per_track(size) + sec - 1) * sector_length(size);
	endfunction

	// ============================================================
	// checks and host bus
	// ============================================================
	task automatic stop_run();
		$display("TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
		addr = a;
		din = d;
		io_en = 1'b1;
		wr = 1'b1;
		@(negedge clk_sys);
		wr = 1'b0; // falling edge serves a data byte
		@(negedge clk_sys);
		io_en = 1'b0;
	endtask

	task automatic bus_read(input logic [1:0] a, output logic [7:0] d);
		addr = a;
		io_en = 1'b1;
		rd = 1'b1;
		@(negedge clk_sys);
		d = dout;
		rd = 1'b0;
		@(negedge clk_sys);
		io_en = 1'b0;
	endtask

	task automatic wait_intrq(input string name);
		int n;
		n = 0;
		while (!intrq) begin
			@(negedge clk_sys);
			n++;
			if (n > WAIT_LIMIT) begin
				$display("%s: the interrupt request never came", name);
				stop_run();
			end
		end
	endtask

	task automatic seek_to(input logic [7:0] trk, input string name);
		logic [7:0] v;
		bus_write(fdc_pkg::A_DATA, trk);
		bus_write(fdc_pkg::A_STATUS, 8'h10);
		wait_intrq(name);
		bus_read(fdc_pkg::A_STATUS, v); // clears intrq
	endtask

	// serve drq until the command ends
	task automatic transfer(input row_t r, input int off, input string name,
		output int served);
		int idle;
		logic forced;
		logic [7:0] v;
		served = 0;
		idle = 0;
		forced = 1'b0;
		while (!intrq) begin
			if (drq && !forced) begin
				if (r.kind != fdc_pkg::OP_FORCE_INT && served >= r.count) begin
					$display("%s: more data requests than the command moves", name);
					stop_run();
				end
				if (r.kind == fdc_pkg::OP_FORCE_INT) begin
					bus_write(fdc_pkg::A_STATUS, 8'hd0);
					forced = 1'b1;
				end else if (r.kind == fdc_pkg::OP_WRITE_SECTOR) begin
					rand_state = xorshift32(rand_state);
					sent.push_back(rand_state[7:0]);
					bus_write(fdc_pkg::A_DATA, rand_state[7:0]);
					served++;
				end else begin
					bus_read(fdc_pkg::A_DATA, v);
					check($sformatf("%s byte %0d", name, served), image_byte(off + served), v);
					served++;
				end
				idle = 0;
			end else begin
				@(negedge clk_sys);
				idle++;
				if (idle > WAIT_LIMIT) begin
					$display("%s: no data request and no end of command", name);
					stop_run();
				end
			end
		end
	endtask

	task automatic check_written(input int off, input int count, input string name);
		int k;
		for (k = 0; k < count; k++)
			check($sformatf("%s image byte %0d", name, k), sent[k], img.mem[off + k]);
		check($sformatf("%s byte below", name), image_byte(off - 1), img.mem[off - 1]);
		check($sformatf("%s byte above", name), image_byte(off + count), img.mem[off + count]);
	endtask

	// ============================================================
	// stimulus
	// ============================================================
	task automatic fill_image();
		int n;
		for (n = 0; n < 65536; n++)
			img.mem[n] = image_byte(n);
	endtask

	task automatic fill_table();
		// kind                     cmd    size  track  sd    sec     wp    count    status trk    sec
		rows[0]  = {fdc_pkg::OP_SEEK,   8'h10, 3'd0, 8'd5,  1'b0, 8'd0,  1'b0, 12'd0,    8'h00, 8'd5,  8'd0};
		rows[1]  = {fdc_pkg::OP_STEP,   8'h50, 3'd0, 8'd0,  1'b0, 8'd0,  1'b0, 12'd0,    8'h00, 8'd6,  8'd0};
		rows[2]  = {fdc_pkg::OP_STEP,   8'h60, 3'd0, 8'd0,  1'b0, 8'd0,  1'b0, 12'd0,    8'h00, 8'd6,  8'd0};
		rows[3]  = {fdc_pkg::OP_SEEK,   8'h10, 3'd0, 8'd1,  1'b0, 8'd0,  1'b0, 12'd0,    8'h00, 8'd1,  8'd0};
		rows[4]  = {fdc_pkg::OP_STEP,   8'h60, 3'd0, 8'd0,  1'b0, 8'd0,  1'b0, 12'd0,    8'h04, 8'd1,  8'd0};
		rows[5]  = {fdc_pkg::OP_RESTORE, 8'h00, 3'd0, 8'd0, 1'b0, 8'd0,  1'b0, 12'd0,    8'h04, 8'd0,  8'd0};
		rows[6]  = {fdc_pkg::OP_READ_SECTOR, 8'h80, 3'd0, 8'd3, 1'b1, 8'd5, 1'b0, 12'd128, 8'h00, 8'd3, 8'd5};
		rows[7]  = {fdc_pkg::OP_READ_SECTOR, 8'h80, 3'd1, 8'd4, 1'b1, 8'd16, 1'b0, 12'd256, 8'h00, 8'd4, 8'd16};
		rows[8]  = {fdc_pkg::OP_READ_SECTOR, 8'h80, 3'd2, 8'd1, 1'b0, 8'd9, 1'b0, 12'd512, 8'h00, 8'd1, 8'd9};
		rows[9]  = {fdc_pkg::OP_READ_SECTOR, 8'h80, 3'd3, 8'd2, 1'b1, 8'd3, 1'b0, 12'd1024, 8'h00, 8'd2, 8'd3};
		rows[10] = {fdc_pkg::OP_READ_SECTOR, 8'h80, 3'd4, 8'd5, 1'b0, 8'd10, 1'b0, 12'd512, 8'h00, 8'd5, 8'd10};
		rows[11] = {fdc_pkg::OP_WRITE_SECTOR, 8'ha0, 3'd0, 8'd9, 1'b1, 8'd2, 1'b0, 12'd128, 8'h00, 8'd9, 8'd2};
		rows[12] = {fdc_pkg::OP_READ_SECTOR, 8'h90, 3'd1, 8'd2, 1'b0, 8'd15, 1'b0, 12'd512, 8'h00, 8'd2, 8'd16};
		rows[13] = {fdc_pkg::OP_READ_SECTOR, 8'h80, 3'd2, 8'd1, 1'b0, 8'd0, 1'b0, 12'd0, 8'h10, 8'd1, 8'd0};
		rows[14] = {fdc_pkg::OP_READ_SECTOR, 8'h80, 3'd2, 8'd1, 1'b0, 8'd10, 1'b0, 12'd0, 8'h10, 8'd1, 8'd10};
		rows[15] = {fdc_pkg::OP_WRITE_SECTOR, 8'ha0, 3'd2, 8'd1, 1'b0, 8'd3, 1'b1, 12'd0, 8'h60, 8'd1, 8'd3};
		rows[16] = {fdc_pkg::OP_FORCE_INT, 8'h80, 3'd4, 8'd3, 1'b0, 8'd2, 1'b0, 12'd0, 8'h00, 8'd3, 8'd2};
	endtask

	task automatic check_reset();
		logic [7:0] v;
		check("reset busy", 0, busy);
		check("reset drq", 0, drq);
		check("reset intrq", 0, intrq);
		check("reset sd_rd", 0, sd_rd);
		check("reset sd_wr", 0, sd_wr);
		bus_read(fdc_pkg::A_STATUS, v);
		check("reset status", 8'h04, v);
		bus_write(fdc_pkg::A_TRACK, 8'h2a);
		bus_read(fdc_pkg::A_TRACK, v);
		check("track readback", 8'h2a, v);
		bus_write(fdc_pkg::A_SECTOR, 8'h07);
		bus_read(fdc_pkg::A_SECTOR, v);
		check("sector readback", 8'h07, v);
	endtask

	task automatic run_row(input row_t r, input int idx);
		string name;
		logic [7:0] v;
		int off, served, reqs;
		name = $sformatf("row %0d", idx);
		size_code = r.size;
		side = r.side;
		wp = r.wp;
		if (r.kind == fdc_pkg::OP_RESTORE || r.kind == fdc_pkg::OP_SEEK ||
			r.kind == fdc_pkg::OP_STEP) begin
			bus_write(fdc_pkg::A_DATA, r.track);
			bus_write(fdc_pkg::A_STATUS, r.cmd);
			check($sformatf("%s busy after command", name), 1, busy);
			wait_intrq(name);
			check($sformatf("%s busy at end", name), 0, busy);
			bus_read(fdc_pkg::A_TRACK, v);
			check($sformatf("%s track", name), r.exp_track, v);
			bus_read(fdc_pkg::A_STATUS, v);
			check($sformatf("%s status", name), r.status, v);
			check($sformatf("%s intrq after status read", name), 0, intrq);
		end else begin
			seek_to(r.track, name);
			bus_write(fdc_pkg::A_SECTOR, r.sector);
			off = image_offset(r.size, r.track, r.side, r.sector);
			reqs = img.req_count;
			sent.delete();
			bus_write(fdc_pkg::A_STATUS, r.cmd);
			transfer(r, off, name, served);
			check($sformatf("%s byte count", name), r.count, served);
			if (r.count != 0)
				check($sformatf("%s last block address", name), (off + r.count - 1) / 512,
					img.last_lba);
			check($sformatf("%s busy at end", name), 0, busy);
			check($sformatf("%s drq at end", name), 0, drq);
			bus_read(fdc_pkg::A_STATUS, v);
			check($sformatf("%s status", name), r.status, v);
			bus_read(fdc_pkg::A_TRACK, v);
			check($sformatf("%s track", name), r.exp_track, v);
			bus_read(fdc_pkg::A_SECTOR, v);
			check($sformatf("%s sector", name), r.exp_sector, v);
			if (r.wp)
				check($sformatf("%s storage requests", name), reqs, img.req_count);
			if (r.kind == fdc_pkg::OP_WRITE_SECTOR && r.count != 0)
				check_written(off, r.count, name);
		end
	endtask

	initial begin
		arst_n = 1'b0;
		ce = 1'b1;
		ready = 1'b1;
		io_en = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		addr = '0;
		din = '0;
		wp = 1'b0;
		side = 1'b0;
		size_code = '0;
		rand_state = SEED;
		fill_image();
		fill_table();
		repeat (10) @(negedge clk_sys);
		arst_n = 1'b1;
		@(negedge clk_sys);
		check_reset();
		for (i = 0; i < NROWS; i++)
			run_row(rows[i], i);
		$display("TESTS PASSED");
		$finish;
	end
endmodule

// ==== files.f ====
design/fdc_pkg.sv
design/fdc_geometry.sv
design/sector_buffer.sv
design/fdc_registers.sv
design/fdc_sequencer.sv
design/fdc_top.sv
tests/sd_image_model.sv
tests/tb_fdc.sv

// ==== Bender.yml ====
package:
  name: fdc_wd1793

sources:
  - design/fdc_pkg.sv
  - design/fdc_geometry.sv
  - design/sector_buffer.sv
  - design/fdc_registers.sv
  - design/fdc_sequencer.sv
  - design/fdc_top.sv
  - target: test
    files:
      - tests/sd_image_model.sv
      - tests/tb_fdc.sv
